// ==== bench/read_vectors.txt ====
// Columns: command, group mask, value, expected AFI word (all hex)
// Commands: 1 capture, 2 read, 3 set latency, 4 FIFO clear, 5 idle cycles, 0 end
3 0 00000003 00000000
1 3 76543210 00000000
1 3 89abcdef 00000000
2 0 00000000 73625140
5 0 0000000c 00000000
2 0 00000000 8c9daebf
5 0 00000014 00000000
3 0 00000007 00000000
1 3 0f1e2d3c 00000000
1 3 deadbeef 00000000
2 0 00000000 02fd13ec
2 0 00000000 dbeeaedf
5 0 00000014 00000000
1 3 12345678 00000000
1 3 cafef00d 00000000
4 3 00000000 00000000
5 0 00000002 00000000
1 3 55aa33cc 00000000
2 0 00000000 5353acac
5 0 00000014 00000000
0 0 00000000 00000000

// ==== all.f ====
logic/rdp_cfg_pkg.sv
logic/rdp_types_pkg.sv
logic/read_fifo_if.sv
logic/read_resync_fifo.sv
logic/read_fifo_bank.sv
logic/read_latency_selector.sv
logic/oct_control.sv
logic/read_datapath_top.sv
bench/read_datapath_checker.sv
bench/tb_read_datapath.sv

// ==== bench/tb_read_datapath.sv ====
// Run from the project root so bench/read_vectors.txt is found; captures always use both groups
`timescale 1ns/1ns
`default_nettype none

module tb_read_datapath;

	import rdp_cfg_pkg::*;
	import rdp_types_pkg::*;

	localparam int CLK_HALF_PERIOD = 4;
	localparam int DRIVE_DELAY     = 1;
	localparam int RESET_CYCLES    = 16;
	localparam int MAX_VECTORS     = 64;
	// Each vector line holds command, group mask, value and expected AFI word
	localparam int FIELDS          = 4;
	localparam int CMD_END         = 0;
	localparam int CMD_CAPTURE     = 1;
	localparam int CMD_READ        = 2;
	localparam int CMD_LATENCY     = 3;
	localparam int CMD_CLEAR       = 4;
	localparam int CMD_WAIT        = 5;

	logic                                   pll_afi_clk;
	logic                                   reset_n_afi_clk;
	capture_word_t [MEM_READ_DQS_WIDTH-1:0] ddio_phy_dq;
	group_mask_t                            dq_capture_valid;
	group_mask_t                            seq_read_fifo_reset;
	latency_t                               seq_read_latency_counter;
	logic [AFI_RATE_RATIO-1:0]              afi_rdata_en;
	logic [AFI_RATE_RATIO-1:0]              afi_rdata_en_full;
	afi_word_t                              afi_rdata;
	logic [AFI_RATE_RATIO-1:0]              afi_rdata_valid;
	logic                                   force_oct_off;

	logic [AFI_DATA_WIDTH-1:0] vec_mem [MAX_VECTORS*FIELDS];
	int  cycle = 0;
	int  cycles_out_of_reset = 0;
	int  cycle_limit;
	int  num_vectors;
	int  latency;
	int  value_errors = 0;
	int  event_errors = 0;
	int  assertion_errors = 0;
	// Bit k is the full read enable sampled k edges before the last one
	logic [OCT_OFF_DELAY+1:0] en_full_seen = '0;
	afi_word_t exp_data_q [$];
	int        exp_cycle_q [$];

	read_datapath_top u_read_datapath_top (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.dq_capture_valid_i         (dq_capture_valid),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset),
		.seq_read_latency_counter_i (seq_read_latency_counter),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.afi_rdata_o                (afi_rdata),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off)
	);

	always #CLK_HALF_PERIOD pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk)
	begin
		cycle <= cycle + 1;
		if (reset_n_afi_clk)
			cycles_out_of_reset <= cycles_out_of_reset + 1;
	end

	// ********************************************************************
	// Stimulus
	// ********************************************************************
	task automatic drive_idle();
		ddio_phy_dq         = '0;
		dq_capture_valid    = '0;
		seq_read_fifo_reset = '0;
		afi_rdata_en        = '0;
		afi_rdata_en_full   = '0;
	endtask

	task automatic apply_vector(input int idx);
		logic [AFI_DATA_WIDTH-1:0] cmd;
		logic [AFI_DATA_WIDTH-1:0] mask;
		logic [AFI_DATA_WIDTH-1:0] value;
		cmd   = vec_mem[FIELDS*idx];
		mask  = vec_mem[FIELDS*idx + 1];
		value = vec_mem[FIELDS*idx + 2];
		case (cmd)
			CMD_CAPTURE:
			begin
				ddio_phy_dq      = value;
				dq_capture_valid = mask[MEM_READ_DQS_WIDTH-1:0];
			end
			CMD_READ:
			begin
				afi_rdata_en      = '1;
				afi_rdata_en_full = '1;
				// Sampled on the coming edge, data returns L+1 edges after that
				exp_data_q.push_back(vec_mem[FIELDS*idx + 3]);
				exp_cycle_q.push_back(cycle + latency + 2);
			end
			CMD_LATENCY:
			begin
				latency                  = int'(value);
				seq_read_latency_counter = latency_t'(value);
			end
			CMD_CLEAR:
				seq_read_fifo_reset = mask[MEM_READ_DQS_WIDTH-1:0];
			CMD_WAIT:
				repeat (value) @(posedge pll_afi_clk);
			default:
			begin
				$display("Vector %0d holds an unknown command %0d", idx, cmd);
				event_errors++;
			end
		endcase
	endtask

	// ********************************************************************
	// Response checks, sampled mid-cycle
	// ********************************************************************
	task automatic check_read_return();
		afi_word_t exp_word;
		int        exp_cycle;
		if (afi_rdata_valid === '1)
		begin
			if (exp_cycle_q.size() == 0)
			begin
				$display("Read valid at cycle %0d with no read outstanding", cycle);
				event_errors++;
			end
			else
			begin
				exp_word  = exp_data_q.pop_front();
				exp_cycle = exp_cycle_q.pop_front();
				if (exp_cycle != cycle)
				begin
					$display("Read returned at cycle %0d instead of cycle %0d", cycle, exp_cycle);
					event_errors++;
				end
				if (afi_rdata !== exp_word)
				begin
					$display("Error: afi_rdata_o = %h, expected %h", afi_rdata, exp_word);
					value_errors++;
				end
			end
		end
		else if (afi_rdata_valid !== '0)
		begin
			$display("Error: afi_rdata_valid_o = %h, expected both phases equal", afi_rdata_valid);
			value_errors++;
		end
		else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle)
		begin
			$display("Read due at cycle %0d never returned", exp_cycle_q[0]);
			void'(exp_data_q.pop_front());
			void'(exp_cycle_q.pop_front());
			event_errors++;
		end
	endtask

	task automatic check_oct_window();
		logic expected;
		// Termination is released by enables sampled OFF_DELAY to ON_DELAY edges earlier
		expected = ~(|en_full_seen[OCT_OFF_DELAY+1:OCT_ON_DELAY+1]);
		if (force_oct_off !== expected)
		begin
			$display("Error: force_oct_off_o = %h, expected %h at cycle %0d",
				force_oct_off, expected, cycle);
			value_errors++;
		end
	endtask

	always @(negedge pll_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			if (afi_rdata_valid !== '0)
			begin
				$display("Error: afi_rdata_valid_o = %h, expected 0 in reset", afi_rdata_valid);
				value_errors++;
			end
			if (force_oct_off !== 1'b0)
			begin
				$display("Error: force_oct_off_o = %h, expected 0 in reset", force_oct_off);
				value_errors++;
			end
		end
		else
		begin
			check_read_return();
			// The first edge out of reset is the first one the OCT window applies to
			if (cycles_out_of_reset > 0)
				check_oct_window();
		end
		en_full_seen = {en_full_seen[OCT_OFF_DELAY:0], afi_rdata_en_full[0]};
	end

	// ********************************************************************
	// Run control
	// ********************************************************************
	always @(posedge pll_afi_clk)
	begin
		if (cycle >= cycle_limit)
		begin
			$display("Run stopped at cycle %0d with %0d reads outstanding", cycle, exp_cycle_q.size());
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial
	begin
		pll_afi_clk              = 1'b0;
		reset_n_afi_clk          = 1'b0;
		seq_read_latency_counter = '0;
		latency                  = 0;
		drive_idle();
		for (int i = 0; i < MAX_VECTORS*FIELDS; i++)
			vec_mem[i] = '0;
		$readmemh("bench/read_vectors.txt", vec_mem);
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS && vec_mem[FIELDS*num_vectors] != CMD_END)
			num_vectors++;
		cycle_limit = 40 * num_vectors + 200;
		if (num_vectors == 0)
		begin
			$display("No vectors were loaded from bench/read_vectors.txt");
			event_errors++;
		end
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		#DRIVE_DELAY;
		reset_n_afi_clk = 1'b1;
		for (int i = 0; i < num_vectors; i++)
		begin
			@(posedge pll_afi_clk);
			#DRIVE_DELAY;
			drive_idle();
			apply_vector(i);
		end
		@(posedge pll_afi_clk);
		#DRIVE_DELAY;
		drive_idle();
		// Outstanding reads drain here, a lost one ends the run at the limit
		while (exp_cycle_q.size() != 0)
			@(posedge pll_afi_clk);
		repeat (2) @(posedge pll_afi_clk);
		// Concurrent assertion failures of the bound checker
		assertion_errors =
			u_read_datapath_top.u_read_latency_selector.u_read_datapath_checker.assert_failures;
		$display("Summary: %0d vectors, %0d value errors, %0d event errors, %0d assertion errors",
			num_vectors, value_errors, event_errors, assertion_errors);
		if (value_errors == 0 && event_errors == 0 && assertion_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/read_datapath_checker.sv ====
// Bound into every read_latency_selector; needs a simulator that supports bind and concurrent assertions
`timescale 1ns/1ns
`default_nettype none

module read_datapath_checker (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire read_enable_i,
	input wire read_valid_i
);

	// Count of failed assertions
	int assert_failures = 0;

	// Once out of reset the valid must always resolve to a clean level
	valid_known_a: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown(read_valid_i))
		else
		begin
			$error("read valid is unknown after reset");
			assert_failures++;
		end

	// The controller sees no valid while the path is held in reset
	valid_low_in_reset_a: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> !read_valid_i)
		else
		begin
			$error("read valid is high during reset");
			assert_failures++;
		end

	// Valid only follows an edge on which the FIFOs were actually read
	valid_after_read_a: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		read_valid_i |-> $past(read_enable_i))
		else
		begin
			$error("read valid without a FIFO read on the edge before");
			assert_failures++;
		end

endmodule

bind read_latency_selector read_datapath_checker u_read_datapath_checker (
	.pll_afi_clk     (pll_afi_clk),
	.reset_n_afi_clk (reset_n_afi_clk),
	.read_enable_i   (read_enable_o),
	.read_valid_i    (read_valid_o)
);

`default_nettype wire

// ==== logic/read_datapath_top.sv ====
// Read path top on one clock; only phase 0 of the AFI read enables is used, both valid phases are equal
`timescale 1ns/1ns
`default_nettype none

module read_datapath_top #(
	parameter int FIFO_DEPTH  = rdp_cfg_pkg::READ_FIFO_DEPTH,
	parameter int MAX_LATENCY = rdp_cfg_pkg::MAX_READ_LATENCY,
	parameter int ON_DELAY    = rdp_cfg_pkg::OCT_ON_DELAY,
	parameter int OFF_DELAY   = rdp_cfg_pkg::OCT_OFF_DELAY
) (
	input  wire pll_afi_clk,
	input  wire reset_n_afi_clk,
	input  wire rdp_types_pkg::capture_word_t [rdp_cfg_pkg::MEM_READ_DQS_WIDTH-1:0] ddio_phy_dq_i,
	input  wire rdp_types_pkg::group_mask_t dq_capture_valid_i,
	input  wire rdp_types_pkg::group_mask_t seq_read_fifo_reset_i,
	input  wire rdp_types_pkg::latency_t seq_read_latency_counter_i,
	input  wire [rdp_cfg_pkg::AFI_RATE_RATIO-1:0] afi_rdata_en_i,
	input  wire [rdp_cfg_pkg::AFI_RATE_RATIO-1:0] afi_rdata_en_full_i,
	output wire rdp_types_pkg::afi_word_t afi_rdata_o,
	output wire [rdp_cfg_pkg::AFI_RATE_RATIO-1:0] afi_rdata_valid_o,
	output wire force_oct_off_o
);

	import rdp_cfg_pkg::*;

	// Shared FIFO read enable and the single valid for all groups
	logic read_enable;
	logic read_valid;

	// Every AFI phase carries data in half rate, so both phases see one valid
	assign afi_rdata_valid_o = {AFI_RATE_RATIO{read_valid}};

	// ********************************************************************
	// Latency replay, data FIFOs and termination control
	// ********************************************************************
	read_latency_selector #(
		.MAX_LATENCY (MAX_LATENCY)
	) u_read_latency_selector (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i[0]),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i[0]),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_enable_o              (read_enable),
		.read_valid_o               (read_valid)
	);

	read_fifo_bank #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_read_fifo_bank (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.dq_capture_valid_i    (dq_capture_valid_i),
		.read_enable_i         (read_enable),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.afi_rdata_o           (afi_rdata_o)
	);

	oct_control #(
		.ON_DELAY  (ON_DELAY),
		.OFF_DELAY (OFF_DELAY)
	) u_oct_control (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i[0]),
		.force_oct_off_o     (force_oct_off_o)
	);

endmodule

`default_nettype wire

// ==== logic/oct_control.sv ====
// Forces on-die termination off around reads; OFF_DELAY must be at least 1 and not below ON_DELAY
`timescale 1ns/1ns
`default_nettype none

module oct_control #(
	parameter int ON_DELAY  = rdp_cfg_pkg::OCT_ON_DELAY,
	parameter int OFF_DELAY = rdp_cfg_pkg::OCT_OFF_DELAY
) (
	input  wire  pll_afi_clk,
	input  wire  reset_n_afi_clk,
	input  wire  afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	// Bit k holds the full read enable sampled k edges before the current one
	logic [OFF_DELAY:0] rdata_en_hist;

	// ********************************************************************
	// Termination window
	// ********************************************************************
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist   <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_hist   <= {rdata_en_hist[OFF_DELAY-1:0], afi_rdata_en_full_i};
			// Termination stays released while any enable is inside the window
			force_oct_off_o <= ~(|rdata_en_hist[OFF_DELAY:ON_DELAY]);
		end
	end

endmodule

`default_nettype wire

// ==== logic/read_latency_selector.sv ====
// Replays phase-0 read enables after the programmed latency; valid taps beyond MAX_LATENCY-1 are not supported
`timescale 1ns/1ns
`default_nettype none

module read_latency_selector #(
	parameter int MAX_LATENCY = rdp_cfg_pkg::MAX_READ_LATENCY
) (
	input  wire  pll_afi_clk,
	input  wire  reset_n_afi_clk,
	input  wire  afi_rdata_en_i,
	input  wire  afi_rdata_en_full_i,
	input  wire  rdp_types_pkg::latency_t seq_read_latency_counter_i,
	output logic read_enable_o,
	output logic read_valid_o
);

	// ********************************************************************
	// Delay lines
	// ********************************************************************
	// Bit k holds the enable that was sampled k edges ago
	logic [MAX_LATENCY-1:0] latency_shifter;
	logic [MAX_LATENCY-1:0] full_latency_shifter;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter      <= '0;
			full_latency_shifter <= '0;
		end
		else
		begin
			latency_shifter      <= {latency_shifter[MAX_LATENCY-2:0], afi_rdata_en_i};
			full_latency_shifter <= {full_latency_shifter[MAX_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// ********************************************************************
	// Latency taps
	// ********************************************************************
	// The FIFO read enable comes straight from the full line so that the
	// FIFO word and the valid below land on the same edge
	assign read_enable_o = full_latency_shifter[seq_read_latency_counter_i];

	// Valid is one register behind the tap, aligned with the FIFO read data
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			read_valid_o <= 1'b0;
		else
			read_valid_o <= latency_shifter[seq_read_latency_counter_i];
	end

endmodule

`default_nettype wire

// ==== logic/read_fifo_bank.sv ====
// One resync FIFO per DQS group sharing one read enable; output is reordered into AFI time-slot order
`timescale 1ns/1ns
`default_nettype none

module read_fifo_bank #(
	parameter int FIFO_DEPTH = rdp_cfg_pkg::READ_FIFO_DEPTH
) (
	input  wire pll_afi_clk,
	input  wire reset_n_afi_clk,
	input  wire rdp_types_pkg::capture_word_t [rdp_cfg_pkg::MEM_READ_DQS_WIDTH-1:0] ddio_phy_dq_i,
	input  wire rdp_types_pkg::group_mask_t dq_capture_valid_i,
	input  wire read_enable_i,
	input  wire rdp_types_pkg::group_mask_t seq_read_fifo_reset_i,
	output wire rdp_types_pkg::afi_word_t afi_rdata_o
);

	import rdp_cfg_pkg::*;
	import rdp_types_pkg::*;

	// Sequencer clear, delayed by one register before it reaches the pointers
	group_mask_t fifo_clear_r;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			fifo_clear_r <= '0;
		else
			fifo_clear_r <= seq_read_fifo_reset_i;
	end

	// ********************************************************************
	// Per-group FIFO and output reordering
	// ********************************************************************
	for (genvar g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin : g_group
		read_fifo_if fifo_if ();

		// Group g owns slice g of the capture bus
		assign fifo_if.capture_valid = dq_capture_valid_i[g];
		assign fifo_if.capture_data  = ddio_phy_dq_i[g];
		assign fifo_if.read_enable   = read_enable_i;
		assign fifo_if.fifo_clear    = fifo_clear_r[g];

		read_resync_fifo #(
			.DEPTH (FIFO_DEPTH)
		) u_read_resync_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.fifo            (fifo_if.fifo_mp)
		);

		// FIFO words are group-major, AFI wants every group of slot t side by side
		for (genvar t = 0; t < TIMESLOTS; t++)
		begin : g_slot
			assign afi_rdata_o[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*g +: DQ_GROUP_WIDTH] =
				fifo_if.read_data[DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH];
		end
	end

endmodule

`default_nettype wire

// ==== logic/read_resync_fifo.sv ====
// Flop FIFO for one DQS group; no full or empty flags, so overflow overwrites and underflow rereads stale words
`timescale 1ns/1ns
`default_nettype none

module read_resync_fifo #(
	parameter int DEPTH = rdp_cfg_pkg::READ_FIFO_DEPTH
) (
	input  wire          pll_afi_clk,
	input  wire          reset_n_afi_clk,
	read_fifo_if.fifo_mp fifo
);

	import rdp_types_pkg::*;

	// A depth of one still needs a single pointer bit
	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	capture_word_t        mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;

	// Pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// ********************************************************************
	// Pointer control
	// ********************************************************************
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (fifo.fifo_clear)
		begin
			// Clear from the sequencer discards every unread entry
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (fifo.capture_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (fifo.read_enable)
				rd_ptr <= ptr_next(rd_ptr);
		end
	end

	// ********************************************************************
	// Storage and registered read port
	// ********************************************************************
	always_ff @(posedge pll_afi_clk)
	begin
		if (fifo.capture_valid && !fifo.fifo_clear)
			mem[wr_ptr] <= fifo.capture_data;
	end

	// The word leaves on the same edge that advances the read pointer
	always_ff @(posedge pll_afi_clk)
	begin
		if (fifo.read_enable && !fifo.fifo_clear)
			fifo.read_data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// ==== logic/read_fifo_if.sv ====
// Bundle between the FIFO bank and one group's resync FIFO; all signals are on pll_afi_clk
`timescale 1ns/1ns
`default_nettype none

interface read_fifo_if;

	import rdp_types_pkg::*;

	// Write side, one captured word per strobe
	logic          capture_valid;
	capture_word_t capture_data;

	// Read side, the pointer advances on each enabled edge
	logic          read_enable;
	// Synchronous clear of both pointers from the sequencer
	logic          fifo_clear;
	// Registered word that was read on the last enabled edge
	capture_word_t read_data;

	modport bank_mp (
		output capture_valid,
		output capture_data,
		output read_enable,
		output fifo_clear,
		input  read_data
	);

	modport fifo_mp (
		input  capture_valid,
		input  capture_data,
		input  read_enable,
		input  fifo_clear,
		output read_data
	);

endinterface

`default_nettype wire

// ==== logic/rdp_types_pkg.sv ====
// Payload types of the read path; all widths follow rdp_cfg_pkg and change only there
`default_nettype none

package rdp_types_pkg;

	import rdp_cfg_pkg::*;

	// One DQS group's captured word, four time slots of DQ_GROUP_WIDTH bits
	// Time slot 0 sits in the low bits
	typedef logic [CAPTURE_GROUP_WIDTH-1:0] capture_word_t;

	// AFI read word, ordered by time slot and then by group inside the slot
	typedef logic [AFI_DATA_WIDTH-1:0] afi_word_t;

	// One bit per read DQS group, used for capture strobes and FIFO clears
	typedef logic [MEM_READ_DQS_WIDTH-1:0] group_mask_t;

	// Read latency as programmed by the sequencer, in AFI cycles
	typedef logic [LATENCY_COUNT_WIDTH-1:0] latency_t;

endpackage

`default_nettype wire

// ==== logic/rdp_cfg_pkg.sv ====
// Default sizes for a half-rate DDR2 read path with two DQS groups; latency taps limited to MAX_READ_LATENCY-1
`default_nettype none

package rdp_cfg_pkg;

	// ********************************************************************
	// Memory side geometry
	// ********************************************************************
	localparam int MEM_DQ_WIDTH        = 8;
	localparam int MEM_READ_DQS_WIDTH  = 2;
	localparam int DQ_GROUP_WIDTH      = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// Half rate gives two AFI phases and four DDR beats per AFI clock
	localparam int AFI_RATE_RATIO      = 2;
	localparam int TIMESLOTS           = 2 * AFI_RATE_RATIO;
	localparam int AFI_DATA_WIDTH      = MEM_DQ_WIDTH * TIMESLOTS;
	localparam int CAPTURE_GROUP_WIDTH = DQ_GROUP_WIDTH * TIMESLOTS;

	// ********************************************************************
	// Read latency and resynchronization FIFO sizing
	// ********************************************************************
	localparam int MAX_READ_LATENCY    = 16;
	localparam int LATENCY_COUNT_WIDTH = $clog2(MAX_READ_LATENCY);
	localparam int READ_FIFO_DEPTH     = 8;

	// Termination window edges in AFI cycles, derived from the CAS latency
	localparam int MEM_T_RL            = 5;
	localparam int OCT_ON_DELAY        = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY       = (MEM_T_RL + 6) / 2;

endpackage

`default_nettype wire
